/* compile.f */
hw/mprj_io_pkg.sv
hw/mprj_ctrl_regs.sv
hw/serial_loader.sv
hw/gpio_ctrl_block.sv
hw/mprj_io_top.sv
testbench/mprj_io_chk.sv
testbench/tb_mprj_io.sv

/* hw/gpio_ctrl_block.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl_block #(
    parameter mprj_io_pkg::io_ctrl_t INIT_CFG = mprj_io_pkg::CTRL_INIT_INPUT
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  mprj_io_pkg::serial_bus_t ser_i,
    output mprj_io_pkg::serial_bus_t ser_o,
    input  logic                     mgmt_out_i,
    output logic                     mgmt_in_o,
    input  logic                     pad_in_i,
    output logic                     pad_out_o,
    output logic                     pad_oe_o
);
    import mprj_io_pkg::*;

    io_ctrl_t shift_q;    // Stage in the serial chain
    io_ctrl_t cfg_q;      // Applied control word
    logic     sclk_q;
    logic     sclk_rise;

    assign sclk_rise = ser_i.sclk && !sclk_q;

    // Clock and load pass straight through, data comes from the stage MSB
    assign ser_o = '{sclk: ser_i.sclk, sresetn: ser_i.sresetn, sdata: shift_q[IO_CTRL_BITS-1]};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sclk_q <= 1'b0;
            cfg_q  <= INIT_CFG;
        end else begin
            sclk_q <= ser_i.sclk;
            if (!ser_i.sresetn && ser_i.sclk) begin
                cfg_q <= shift_q;    // Load pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ser_i.sresetn && !ser_i.sclk) begin
            shift_q <= '0;
        end else if (ser_i.sresetn && sclk_rise) begin
            shift_q <= {shift_q[IO_CTRL_BITS-2:0], ser_i.sdata};
        end
    end

    assign pad_oe_o  = ~cfg_q[CTRL_OEB_BIT];
    assign pad_out_o = mgmt_out_i;
    assign mgmt_in_o = cfg_q[CTRL_INP_DIS_BIT] ? 1'b0 : pad_in_i;

endmodule

`default_nettype wire

/* hw/mprj_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mprj_ctrl_regs (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  mprj_io_pkg::wb_addr_t                         wb_adr_i,
    input  mprj_io_pkg::wb_data_t                         wb_dat_i,
    input  logic [3:0]                                    wb_sel_i,
    input  logic                                          wb_we_i,
    input  logic                                          wb_cyc_i,
    input  logic                                          wb_stb_i,
    output mprj_io_pkg::wb_data_t                         wb_dat_o,
    output logic                                          wb_ack_o,
    input  logic                                          busy_i,
    input  mprj_io_pkg::pad_vec_t                         mgmt_in_i,
    output logic                                          xfer_o,
    output mprj_io_pkg::io_ctrl_t [mprj_io_pkg::IO_PADS-1:0] cfg_words_o,
    output mprj_io_pkg::pad_vec_t                         mgmt_out_o
);
    import mprj_io_pkg::*;

    logic [7:0] adr_lo;
    logic       acc;       // Valid in-window request, not yet acknowledged
    logic       wr_en;
    logic       sel_data;
    logic       sel_xfer;
    pad_vec_t   cfg_sel;
    wb_data_t   rdata;

    assign adr_lo   = wb_adr_i[7:0];
    assign acc      = wb_cyc_i && wb_stb_i && !wb_ack_o &&
                      (wb_adr_i[31:8] == BASE_ADR[31:8]);
    assign wr_en    = acc && wb_we_i && wb_sel_i[0];  // Byte lane 0 gates all writes
    assign sel_data = (adr_lo == ADR_DATA);
    assign sel_xfer = (adr_lo == ADR_XFER);

    for (genvar i = 0; i < IO_PADS; i++) begin : g_sel
        assign cfg_sel[i] = (adr_lo == ADR_CFG + 8'(4 * i));
    end

    // Read data mux, unmapped offsets give zero
    always_comb begin
        rdata = '0;
        if (sel_data) begin
            rdata[IO_PADS-1:0] = mgmt_in_i;
        end else if (sel_xfer) begin
            rdata[0] = busy_i;
        end else begin
            for (int i = 0; i < IO_PADS; i++) begin
                if (cfg_sel[i]) begin
                    rdata[IO_CTRL_BITS-1:0] = cfg_words_o[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_ack_o   <= 1'b0;
            xfer_o     <= 1'b0;
            mgmt_out_o <= '0;
            for (int i = 0; i < IO_PADS; i++) begin
                cfg_words_o[i] <= ctrl_init_word(i);
            end
        end else begin
            wb_ack_o <= acc;
            // Self-clearing, lasts only the ack cycle
            xfer_o   <= wr_en && sel_xfer && wb_dat_i[0];

            if (wr_en && sel_data) begin
                mgmt_out_o <= wb_dat_i[IO_PADS-1:0];
            end

            for (int i = 0; i < IO_PADS; i++) begin
                if (wr_en && cfg_sel[i]) begin
                    cfg_words_o[i] <= wb_dat_i[IO_CTRL_BITS-1:0];
                end
            end
        end
    end

    // Read data is captured on the ack edge
    always_ff @(posedge clk) begin
        if (acc) begin
            wb_dat_o <= rdata;
        end
    end

endmodule

`default_nettype wire

/* hw/mprj_io_pkg.sv */
`default_nettype none

package mprj_io_pkg;

    localparam int IO_PADS      = 8;
    localparam int IO_CTRL_BITS = 13;
    localparam int BIDIR_PADS   = 2;   // Low pads that come up bidirectional

    // Register window, decoded on address bits 31:8
    localparam logic [31:0] BASE_ADR = 32'h2300_0000;
    localparam logic [7:0]  ADR_DATA = 8'h00;
    localparam logic [7:0]  ADR_XFER = 8'h04;
    localparam logic [7:0]  ADR_CFG  = 8'h08;  // Pad i at ADR_CFG + 4*i

    localparam int CTRL_OEB_BIT     = 1;  // 1 disables the pad output
    localparam int CTRL_INP_DIS_BIT = 3;  // 1 forces management input to 0

    typedef logic [IO_CTRL_BITS-1:0]          io_ctrl_t;
    typedef logic [IO_PADS-1:0]               pad_vec_t;
    typedef logic [31:0]                      wb_data_t;
    typedef logic [31:0]                      wb_addr_t;
    typedef logic [$clog2(IO_CTRL_BITS)-1:0]  bit_cnt_t;
    typedef logic [$clog2(IO_PADS)-1:0]       pad_idx_t;

    localparam io_ctrl_t CTRL_INIT_BIDIR = 13'h1801;
    localparam io_ctrl_t CTRL_INIT_INPUT = 13'h0403;

    typedef struct packed {
        logic sclk;
        logic sresetn;   // Low while sclk is high loads the chain
        logic sdata;
    } serial_bus_t;

    typedef enum logic [1:0] {IDLE, START, XBYTE, LOAD} loader_state_t;

    // Reset word of one pad, shared by the register block and the pad blocks
    function automatic io_ctrl_t ctrl_init_word(input int pad);
        return (pad < BIDIR_PADS) ? CTRL_INIT_BIDIR : CTRL_INIT_INPUT;
    endfunction

endpackage

`default_nettype wire

/* hw/mprj_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mprj_io_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  mprj_io_pkg::wb_addr_t wb_adr_i,
    input  mprj_io_pkg::wb_data_t wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    input  logic                  wb_we_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    output mprj_io_pkg::wb_data_t wb_dat_o,
    output logic                  wb_ack_o,
    input  mprj_io_pkg::pad_vec_t pad_in_i,
    output mprj_io_pkg::pad_vec_t pad_out_o,
    output mprj_io_pkg::pad_vec_t pad_oe_o
);
    import mprj_io_pkg::*;

    logic                      xfer;
    logic                      busy;
    io_ctrl_t [IO_PADS-1:0]    cfg_words;
    pad_vec_t                  mgmt_out;
    pad_vec_t                  mgmt_in;
    serial_bus_t [IO_PADS:0]   ser_chain;  // Loader drives entry 0, the highest pad ends the chain

    mprj_ctrl_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .busy_i      (busy),
        .mgmt_in_i   (mgmt_in),
        .xfer_o      (xfer),
        .cfg_words_o (cfg_words),
        .mgmt_out_o  (mgmt_out)
    );

    serial_loader u_loader (
        .clk         (clk),
        .resetn      (resetn),
        .xfer_i      (xfer),
        .cfg_words_i (cfg_words),
        .busy_o      (busy),
        .ser_o       (ser_chain[0])
    );

    // The first word sent travels furthest, so it lands in the highest pad
    for (genvar i = 0; i < IO_PADS; i++) begin : g_pad
        gpio_ctrl_block #(
            .INIT_CFG (ctrl_init_word(i))
        ) u_gpio_ctrl (
            .clk        (clk),
            .resetn     (resetn),
            .ser_i      (ser_chain[i]),
            .ser_o      (ser_chain[i+1]),
            .mgmt_out_i (mgmt_out[i]),
            .mgmt_in_o  (mgmt_in[i]),
            .pad_in_i   (pad_in_i[i]),
            .pad_out_o  (pad_out_o[i]),
            .pad_oe_o   (pad_oe_o[i])
        );
    end

endmodule

`default_nettype wire

/* hw/serial_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_loader (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          xfer_i,
    input  mprj_io_pkg::io_ctrl_t [mprj_io_pkg::IO_PADS-1:0] cfg_words_i,
    output logic                                          busy_o,
    output mprj_io_pkg::serial_bus_t                      ser_o
);
    import mprj_io_pkg::*;

    loader_state_t state;
    bit_cnt_t      bit_cnt;    // Bit in XBYTE, step in LOAD
    pad_idx_t      pad_idx;    // Counts down from the highest pad
    logic          sclk_q;
    logic          sresetn_q;
    io_ctrl_t      staging;

    assign busy_o = (state != IDLE);
    assign ser_o  = '{sclk: sclk_q, sresetn: sresetn_q, sdata: staging[IO_CTRL_BITS-1]};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= IDLE;
            bit_cnt   <= '0;
            pad_idx   <= pad_idx_t'(IO_PADS - 1);
            sclk_q    <= 1'b0;
            sresetn_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pad_idx   <= pad_idx_t'(IO_PADS - 1);
                    sclk_q    <= 1'b0;
                    sresetn_q <= 1'b1;
                    if (xfer_i) begin
                        state <= START;
                    end
                end
                START: begin
                    bit_cnt <= '0;
                    sclk_q  <= 1'b0;
                    state   <= XBYTE;
                end
                XBYTE: begin
                    sclk_q <= ~sclk_q;
                    if (!sclk_q) begin             // Rising serial edge
                        if (bit_cnt == bit_cnt_t'(IO_CTRL_BITS - 1)) begin
                            bit_cnt <= '0;
                            if (pad_idx == '0) begin
                                state <= LOAD;
                            end else begin
                                pad_idx <= pad_idx - 1'b1;
                                state   <= START;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                LOAD: begin
                    // Hold clock high, pulse reset low once, then drop clock
                    bit_cnt <= bit_cnt + 1'b1;
                    case (bit_cnt)
                        bit_cnt_t'(0): sclk_q <= 1'b1;
                        bit_cnt_t'(1): sresetn_q <= 1'b0;
                        bit_cnt_t'(2): sresetn_q <= 1'b1;
                        default: begin
                            sclk_q <= 1'b0;
                            state  <= IDLE;
                        end
                    endcase
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Word staging, MSB first, shifted as the serial clock falls
    always_ff @(posedge clk) begin
        if (state == START) begin
            staging <= cfg_words_i[pad_idx];
        end else if (state == XBYTE && sclk_q) begin
            staging <= {staging[IO_CTRL_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mprj_io -f compile.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/mprj_io_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mprj_io_chk (
    input logic                     clk,
    input logic                     resetn,
    input logic                     ack_i,
    input logic                     xfer_i,
    input mprj_io_pkg::serial_bus_t ser_i
);
    logic armed;    // High from the second cycle after reset, loader is in IDLE by then
    bit   failed;   // Latched on any assertion failure

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (!resetn) ack_i |=> !ack_i)
        else begin
            failed = 1'b1;
            $error("wb_ack_o stayed high for more than one cycle");
        end

    xfer_single: assert property (@(posedge clk) disable iff (!resetn) xfer_i |=> !xfer_i)
        else begin
            failed = 1'b1;
            $error("Transfer pulse stayed high for more than one cycle");
        end

    // Chain load only with the serial clock held high
    load_with_sclk: assert property (@(posedge clk) disable iff (!resetn)
        (armed && !ser_i.sresetn) |-> ser_i.sclk)
        else begin
            failed = 1'b1;
            $error("Serial reset went low while the serial clock was low");
        end

endmodule

bind mprj_io_top mprj_io_chk u_chk (
    .clk    (clk),
    .resetn (resetn),
    .ack_i  (wb_ack_o),
    .xfer_i (xfer),
    .ser_i  (ser_chain[0])
);

`default_nettype wire

/* testbench/tb_mprj_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mprj_io;
    import mprj_io_pkg::*;

    localparam int ACK_LIMIT  = 20;     // Cycles to wait for an acknowledge
    localparam int BUSY_LIMIT = 500;    // Busy polls before giving up

    logic       clk;
    logic       resetn;
    wb_addr_t   wb_adr;
    wb_data_t   wb_dat_w;
    logic [3:0] wb_sel;
    logic       wb_we;
    logic       wb_cyc;
    logic       wb_stb;
    wb_data_t   wb_dat_r;
    logic       wb_ack;
    pad_vec_t   pad_in;
    pad_vec_t   pad_out;
    pad_vec_t   pad_oe;

    logic [31:0] lfsr;
    io_ctrl_t    reg_model [IO_PADS];   // Words held in the register block
    io_ctrl_t    applied   [IO_PADS];   // Words captured by the pad blocks
    pad_vec_t    data_model;            // Last value written to the data register

    mprj_io_top u_mprj_io_top (
        .clk      (clk),
        .resetn   (resetn),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .pad_in_i (pad_in),
        .pad_out_o(pad_out),
        .pad_oe_o (pad_oe)
    );

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Expected {output enable, input toward management} of one pad
    function automatic logic [1:0] exp_pad(input io_ctrl_t word, input logic pin);
        logic oe;
        logic gated;
        oe    = !word[CTRL_OEB_BIT];
        gated = word[CTRL_INP_DIS_BIT] ? 1'b0 : pin;
        return {oe, gated};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic wb_cycle(input wb_addr_t adr, input logic we, input wb_data_t wdata,
                            output wb_data_t rdata);
        int n;
        n = 0;
        @(posedge clk);
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        wb_we    <= we;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (n > ACK_LIMIT) begin
                fail_run($sformatf("No acknowledge for the access to address %h", adr));
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] off, input wb_data_t data);
        wb_data_t unused;
        wb_cycle({BASE_ADR[31:8], off}, 1'b1, data, unused);
    endtask

    task automatic wb_read(input logic [7:0] off, output wb_data_t data);
        wb_cycle({BASE_ADR[31:8], off}, 1'b0, '0, data);
    endtask

    // Write outside the window, must never be acknowledged
    task automatic probe_outside(input wb_addr_t adr, input wb_data_t data);
        @(posedge clk);
        wb_adr   <= adr;
        wb_dat_w <= data;
        wb_we    <= 1'b1;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        for (int n = 0; n < ACK_LIMIT; n++) begin
            @(posedge clk);
            if (wb_ack) begin
                fail_run($sformatf("Access to address %h outside the window was acknowledged", adr));
            end
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_random_words();
        for (int i = 0; i < IO_PADS; i++) begin
            reg_model[i] = io_ctrl_t'(next_bits(IO_CTRL_BITS));
            wb_write(ADR_CFG + 8'(4 * i), 32'(reg_model[i]));
        end
    endtask

    task automatic check_cfg_words(input string name);
        wb_data_t rd;
        for (int i = 0; i < IO_PADS; i++) begin
            wb_read(ADR_CFG + 8'(4 * i), rd);
            check($sformatf("%s_pad%0d", name, i), 32'(reg_model[i]), rd);
        end
    endtask

    // Start a transfer, then poll busy until the chain is loaded
    task automatic run_transfer(input string name);
        wb_data_t rd;
        int       n;
        n = 0;
        wb_write(ADR_XFER, 32'h1);
        wb_read(ADR_XFER, rd);
        check({name, "_busy"}, 32'h1, rd);
        while (rd[0]) begin
            n++;
            if (n > BUSY_LIMIT) begin
                fail_run("Serial transfer did not finish, busy stayed high");
            end
            wb_read(ADR_XFER, rd);
        end
        for (int i = 0; i < IO_PADS; i++) begin
            applied[i] = reg_model[i];
        end
    endtask

    // Random pad inputs, then output enables and gated data readback
    task automatic check_pads(input string name);
        wb_data_t rd;
        pad_vec_t pins;
        pad_vec_t exp_oe;
        pad_vec_t exp_in;
        pins = pad_vec_t'(next_bits(IO_PADS));
        @(posedge clk);
        pad_in <= pins;
        for (int i = 0; i < IO_PADS; i++) begin
            {exp_oe[i], exp_in[i]} = exp_pad(applied[i], pins[i]);
        end
        wb_read(ADR_DATA, rd);
        check({name, "_oe"}, 32'(exp_oe), 32'(pad_oe));
        check({name, "_in"}, 32'(exp_in), rd);
    endtask

    task automatic check_data_out(input string name);
        data_model = pad_vec_t'(next_bits(IO_PADS));
        wb_write(ADR_DATA, 32'(data_model));
        check(name, 32'(data_model), 32'(pad_out));
    endtask

    initial begin
        wb_data_t rd;
        clk        = 1'b0;
        resetn     = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = 4'hf;
        wb_we      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        pad_in     = '0;
        lfsr       = 32'h6d5f;
        data_model = '0;
        for (int i = 0; i < IO_PADS; i++) begin
            reg_model[i] = (i < BIDIR_PADS) ? CTRL_INIT_BIDIR : CTRL_INIT_INPUT;
            applied[i]   = reg_model[i];
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        check_cfg_words("reset_cfg");
        check_pads("reset_pads");

        write_random_words();
        check_cfg_words("rand_cfg");
        check_pads("stale_pads");    // Pads keep the old words until a transfer

        run_transfer("xfer");
        check_pads("xfer_pads");
        check_data_out("data_out");

        wb_read(ADR_CFG + 8'(4 * IO_PADS), rd);
        check("unmapped", 32'h0, rd);
        probe_outside({BASE_ADR[31:8] + 24'h1, ADR_CFG}, 32'(~reg_model[0]));
        probe_outside({BASE_ADR[31:8] + 24'h1, ADR_DATA}, 32'(~data_model));
        check_cfg_words("outside_cfg");
        check("outside_data", 32'(data_model), 32'(pad_out));

        for (int r = 0; r < 3; r++) begin
            write_random_words();
            run_transfer($sformatf("round%0d_xfer", r));
            check_pads($sformatf("round%0d_pads", r));
            check_data_out($sformatf("round%0d_data", r));
        end

        if (u_mprj_io_top.u_chk.failed) begin
            fail_run("A bus or serial chain assertion failed during the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
